/* hw/rvCorePkg.sv */
package rvCorePkg;

  // Major opcodes
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opOpImm  = 7'b0010011;
  localparam logic [6:0] opOp     = 7'b0110011;
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opAuipc  = 7'b0010111;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opJalr   = 7'b1100111;
  localparam logic [6:0] opSystem = 7'b1110011;

  // Branch and system funct3
  localparam logic [2:0] f3Beq   = 3'b000;
  localparam logic [2:0] f3Bne   = 3'b001;
  localparam logic [2:0] f3Blt   = 3'b100;
  localparam logic [2:0] f3Bge   = 3'b101;
  localparam logic [2:0] f3Bltu  = 3'b110;
  localparam logic [2:0] f3Bgeu  = 3'b111;
  localparam logic [2:0] f3Priv  = 3'b000;
  localparam logic [2:0] f3Csrrw = 3'b001;
  localparam logic [2:0] f3Csrrs = 3'b010;
  localparam logic [2:0] f3Csrrc = 3'b011;

  localparam logic [11:0] f12Ecall  = 12'h000;
  localparam logic [11:0] f12Ebreak = 12'h001;
  localparam logic [11:0] f12Mret   = 12'h302;

  typedef logic [3:0] aluOpT;
  localparam aluOpT aluAdd    = 4'd0;
  localparam aluOpT aluSub    = 4'd1;
  localparam aluOpT aluAnd    = 4'd2;
  localparam aluOpT aluOr     = 4'd3;
  localparam aluOpT aluXor    = 4'd4;
  localparam aluOpT aluSll    = 4'd5;
  localparam aluOpT aluSrl    = 4'd6;
  localparam aluOpT aluSra    = 4'd7;
  localparam aluOpT aluSlt    = 4'd8;
  localparam aluOpT aluSltu   = 4'd9;
  localparam aluOpT aluPassB  = 4'd10;
  localparam aluOpT aluAndNot = 4'd11;

  typedef logic aSelT;
  localparam aSelT aSelReg = 1'b0;
  localparam aSelT aSelPc  = 1'b1;

  typedef logic [1:0] bSelT;
  localparam bSelT bSelReg = 2'd0;
  localparam bSelT bSelImm = 2'd1;
  localparam bSelT bSelCsr = 2'd2;

  typedef logic [1:0] wbSelT;
  localparam wbSelT wbMem = 2'd0;
  localparam wbSelT wbAlu = 2'd1;
  localparam wbSelT wbPc4 = 2'd2;
  localparam wbSelT wbCsr = 2'd3;

  typedef logic [1:0] memSizeT;
  localparam memSizeT memByte = 2'd0;
  localparam memSizeT memHalf = 2'd1;
  localparam memSizeT memWord = 2'd2;

  // One instruction word, six format views
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm4_0;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } instWordT;

  localparam logic [11:0] csrMstatus = 12'h300;
  localparam logic [11:0] csrMtvec   = 12'h305;
  localparam logic [11:0] csrMepc    = 12'h341;
  localparam logic [11:0] csrMcause  = 12'h342;

  localparam logic [31:0] causeEcallM = 32'd11;

endpackage

/* hw/pcUnit.sv */
`timescale 1ns/100ps

module pcUnit #(
  parameter logic [31:0] resetVector = 32'h80000000
) (
  input  logic        clk,
  input  logic        arstN,
  input  logic        pcSel,
  input  logic        ecall,
  input  logic        mret,
  input  logic [31:0] aluOut,
  input  logic [31:0] mtvec,
  input  logic [31:0] mepc,
  output logic [31:0] pc,
  output logic [31:0] pcPlus4,
  output logic [31:0] nextPc
);

  assign pcPlus4 = pc + 32'd4;

  // mret first, then ecall, then jump or branch target
  always_comb begin
    if (mret) begin
      nextPc = mepc;
    end else if (ecall) begin
      nextPc = mtvec;
    end else if (pcSel) begin
      nextPc = {aluOut[31:1], 1'b0};
    end else begin
      nextPc = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc <= resetVector;
    end else begin
      pc <= nextPc;
    end
  end

endmodule

/* hw/decoder.sv */
`timescale 1ns/100ps

module decoder
  import rvCorePkg::*;
(
  input  instWordT    inst,
  input  logic        brEq,
  input  logic        brLt,
  output logic [31:0] imm,
  output logic [4:0]  rs1,
  output logic [4:0]  rs2,
  output logic [4:0]  rd,
  output logic        regWrite,
  output aSelT        aSel,
  output bSelT        bSel,
  output aluOpT       aluOp,
  output wbSelT       wbSel,
  output logic        memRead,
  output logic        memWrite,
  output memSizeT     memSize,
  output logic        memUnsigned,
  output logic        brUn,
  output logic        csrEn,
  output logic        ecall,
  output logic        mret,
  output logic        halt,
  output logic        pcSel
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       taken;

  assign opcode = inst.r.opcode;
  assign funct3 = inst.r.funct3;

  function automatic aluOpT opFromFunct(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  opFromFunct = alt ? aluSub : aluAdd;
      3'b001:  opFromFunct = aluSll;
      3'b010:  opFromFunct = aluSlt;
      3'b011:  opFromFunct = aluSltu;
      3'b100:  opFromFunct = aluXor;
      3'b101:  opFromFunct = alt ? aluSra : aluSrl;
      3'b110:  opFromFunct = aluOr;
      default: opFromFunct = aluAnd;
    endcase
  endfunction

  always_comb begin
    case (opcode)
      opStore:  imm = {{20{inst.s.imm11_5[6]}}, inst.s.imm11_5, inst.s.imm4_0};
      opBranch: imm = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                       inst.b.imm10_5, inst.b.imm4_1, 1'b0};
      opLui,
      opAuipc:  imm = {inst.u.imm31_12, 12'd0};
      opJal:    imm = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                       inst.j.imm11, inst.j.imm10_1, 1'b0};
      default:  imm = {{20{inst.i.imm11_0[11]}}, inst.i.imm11_0};
    endcase
  end

  always_comb begin
    case (funct3)
      f3Beq:         taken = brEq;
      f3Bne:         taken = !brEq;
      f3Blt, f3Bltu: taken = brLt;
      f3Bge, f3Bgeu: taken = !brLt;
      default:       taken = 1'b0;
    endcase
  end

  assign rs1 = inst.r.rs1;
  assign rd  = inst.r.rd;
  // csrrw routes rs1 through the B port so pass-b delivers it
  assign rs2 = (opcode == opSystem && funct3 == f3Csrrw) ? inst.r.rs1 : inst.r.rs2;
  assign brUn        = funct3[1];
  assign memSize     = memSizeT'(funct3[1:0]);
  assign memUnsigned = funct3[2];

  always_comb begin
    regWrite = 1'b0;
    aSel     = aSelReg;
    bSel     = bSelImm;
    aluOp    = aluAdd;
    wbSel    = wbAlu;
    memRead  = 1'b0;
    memWrite = 1'b0;
    csrEn    = 1'b0;
    ecall    = 1'b0;
    mret     = 1'b0;
    halt     = 1'b0;
    pcSel    = 1'b0;
    case (opcode)
      opOp: begin
        regWrite = 1'b1;
        bSel     = bSelReg;
        aluOp    = opFromFunct(funct3, inst.r.funct7[5]);
      end
      opOpImm: begin
        regWrite = 1'b1;
        aluOp    = opFromFunct(funct3, inst.r.funct7[5] && funct3 == 3'b101);
      end
      opLui: begin
        regWrite = 1'b1;
        aluOp    = aluPassB;
      end
      opAuipc: begin
        regWrite = 1'b1;
        aSel     = aSelPc;
      end
      opLoad: begin
        regWrite = 1'b1;
        memRead  = 1'b1;
        wbSel    = wbMem;
      end
      opStore:  memWrite = 1'b1;
      opBranch: begin
        aSel  = aSelPc;
        pcSel = taken;
      end
      opJal, opJalr: begin
        regWrite = 1'b1;
        aSel     = (opcode == opJal) ? aSelPc : aSelReg;
        wbSel    = wbPc4;
        pcSel    = 1'b1;
      end
      opSystem: begin
        if (funct3 == f3Priv) begin
          ecall = inst.i.imm11_0 == f12Ecall;
          halt  = inst.i.imm11_0 == f12Ebreak;
          mret  = inst.i.imm11_0 == f12Mret;
        end else begin
          regWrite = 1'b1;
          csrEn    = 1'b1;
          wbSel    = wbCsr;
          bSel     = (funct3 == f3Csrrw) ? bSelReg : bSelCsr;
          case (funct3)
            f3Csrrs: aluOp = aluOr;
            f3Csrrc: aluOp = aluAndNot;
            default: aluOp = aluPassB;
          endcase
        end
      end
      default: ;
    endcase
  end

endmodule

/* hw/regFile.sv */
`timescale 1ns/100ps

module regFile
  import rvCorePkg::*;
(
  input  logic        clk,
  input  logic        arstN,
  input  logic        wen,
  input  logic [4:0]  waddr,
  input  logic [4:0]  raddr1,
  input  logic [4:0]  raddr2,
  input  wbSelT       wbSel,
  input  logic [31:0] aluOut,
  input  logic [31:0] loadData,
  input  logic [31:0] pcPlus4,
  input  logic [31:0] csrData,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2
);

  logic [31:0] regs [32];
  logic [31:0] wdata;

  // Write-back source
  always_comb begin
    case (wbSel)
      wbMem:   wdata = loadData;
      wbAlu:   wdata = aluOut;
      wbPc4:   wdata = pcPlus4;
      default: wdata = csrData;
    endcase
  end

  // x0 is never written so it keeps its reset zero
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

endmodule

/* hw/alu.sv */
`timescale 1ns/100ps

module alu
  import rvCorePkg::*;
(
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  logic [31:0] imm,
  input  logic [31:0] pc,
  input  logic [31:0] csrData,
  input  aSelT        aSel,
  input  bSelT        bSel,
  input  aluOpT       aluOp,
  input  logic        brUn,
  output logic [31:0] aluOut,
  output logic        brEq,
  output logic        brLt
);

  logic [31:0] opA;
  logic [31:0] opB;

  assign opA = (aSel == aSelPc) ? pc : a;

  always_comb begin
    case (bSel)
      bSelImm: opB = imm;
      bSelCsr: opB = csrData;
      default: opB = b;
    endcase
  end

  always_comb begin
    case (aluOp)
      aluAdd:    aluOut = opA + opB;
      aluSub:    aluOut = opA - opB;
      aluAnd:    aluOut = opA & opB;
      aluOr:     aluOut = opA | opB;
      aluXor:    aluOut = opA ^ opB;
      aluSll:    aluOut = opA << opB[4:0];
      aluSrl:    aluOut = opA >> opB[4:0];
      aluSra:    aluOut = $signed(opA) >>> opB[4:0];
      aluSlt:    aluOut = {31'd0, $signed(opA) < $signed(opB)};
      aluSltu:   aluOut = {31'd0, opA < opB};
      aluPassB:  aluOut = opB;
      // csrrc clears the rs1 bits in the CSR value on B
      aluAndNot: aluOut = opB & ~opA;
      default:   aluOut = '0;
    endcase
  end

  // Branch compare on raw register operands
  assign brEq = a == b;
  assign brLt = brUn ? (a < b) : ($signed(a) < $signed(b));

endmodule

/* hw/csrFile.sv */
`timescale 1ns/100ps

module csrFile
  import rvCorePkg::*;
(
  input  logic        clk,
  input  logic        arstN,
  input  logic        csrEn,
  input  logic        ecall,
  input  logic [11:0] csrId,
  input  logic [31:0] wdata,
  input  logic [31:0] pc,
  output logic [31:0] rdata,
  output logic [31:0] mtvec,
  output logic [31:0] mepc
);

  logic [31:0] mstatus;
  logic [31:0] mcause;

  always_comb begin
    case (csrId)
      csrMstatus: rdata = mstatus;
      csrMtvec:   rdata = mtvec;
      csrMepc:    rdata = mepc;
      csrMcause:  rdata = mcause;
      default:    rdata = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      mstatus <= 32'h1800;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (ecall) begin
      // Trap entry
      mepc   <= pc;
      mcause <= causeEcallM;
    end else if (csrEn) begin
      case (csrId)
        csrMstatus: mstatus <= wdata;
        csrMtvec:   mtvec   <= wdata;
        csrMepc:    mepc    <= wdata;
        csrMcause:  mcause  <= wdata;
        default: ;
      endcase
    end
  end

endmodule

/* hw/loadStoreUnit.sv */
`timescale 1ns/100ps

module loadStoreUnit
  import rvCorePkg::*;
(
  input  logic [31:0] addr,
  input  logic [31:0] storeData,
  input  memSizeT     memSize,
  input  logic        memUnsigned,
  input  logic [31:0] memRdata,
  output logic [31:0] memWdata,
  output logic [3:0]  memWmask,
  output logic [31:0] loadData
);

  logic [31:0] rdShifted;

  // Replicate the store data so every lane holds it
  always_comb begin
    case (memSize)
      memByte: begin
        memWdata = {4{storeData[7:0]}};
        memWmask = 4'b0001 << addr[1:0];
      end
      memHalf: begin
        memWdata = {2{storeData[15:0]}};
        memWmask = 4'b0011 << {addr[1], 1'b0};
      end
      default: begin
        memWdata = storeData;
        memWmask = 4'b1111;
      end
    endcase
  end

  assign rdShifted = memRdata >> {addr[1:0], 3'b000};

  always_comb begin
    case (memSize)
      memByte: loadData = {{24{rdShifted[7] & ~memUnsigned}}, rdShifted[7:0]};
      memHalf: loadData = {{16{rdShifted[15] & ~memUnsigned}}, rdShifted[15:0]};
      default: loadData = memRdata;
    endcase
  end

endmodule

/* hw/rvCore.sv */
`timescale 1ns/100ps

module rvCore
  import rvCorePkg::*;
#(
  parameter logic [31:0] resetVector = 32'h80000000
) (
  input  logic        clk,
  input  logic        arstN,
  input  instWordT    inst,
  output logic [31:0] pc,
  output logic [31:0] nextPc,
  output logic [31:0] memAddr,
  output logic [31:0] memWdata,
  output logic [3:0]  memWmask,
  output logic        memRead,
  output logic        memWrite,
  input  logic [31:0] memRdata,
  output logic        halt
);

  logic [31:0] pcPlus4;
  logic [31:0] imm;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [4:0]  rd;
  logic        regWrite;
  aSelT        aSel;
  bSelT        bSel;
  aluOpT       aluOp;
  wbSelT       wbSel;
  memSizeT     memSize;
  logic        memUnsigned;
  logic        brUn;
  logic        brEq;
  logic        brLt;
  logic        csrEn;
  logic        ecall;
  logic        mret;
  logic        pcSel;
  logic [31:0] rdata1;
  logic [31:0] rdata2;
  logic [31:0] aluOut;
  logic [31:0] csrData;
  logic [31:0] mtvec;
  logic [31:0] mepc;
  logic [31:0] loadData;

  assign memAddr = aluOut;

  pcUnit #(.resetVector(resetVector)) pcUnit_inst (
    .clk(clk), .arstN(arstN), .pcSel(pcSel), .ecall(ecall), .mret(mret),
    .aluOut(aluOut), .mtvec(mtvec), .mepc(mepc),
    .pc(pc), .pcPlus4(pcPlus4), .nextPc(nextPc)
  );

  decoder decoder_inst (
    .inst(inst), .brEq(brEq), .brLt(brLt), .imm(imm),
    .rs1(rs1), .rs2(rs2), .rd(rd), .regWrite(regWrite),
    .aSel(aSel), .bSel(bSel), .aluOp(aluOp), .wbSel(wbSel),
    .memRead(memRead), .memWrite(memWrite), .memSize(memSize),
    .memUnsigned(memUnsigned), .brUn(brUn), .csrEn(csrEn),
    .ecall(ecall), .mret(mret), .halt(halt), .pcSel(pcSel)
  );

  regFile regFile_inst (
    .clk(clk), .arstN(arstN), .wen(regWrite), .waddr(rd),
    .raddr1(rs1), .raddr2(rs2), .wbSel(wbSel), .aluOut(aluOut),
    .loadData(loadData), .pcPlus4(pcPlus4), .csrData(csrData),
    .rdata1(rdata1), .rdata2(rdata2)
  );

  alu alu_inst (
    .a(rdata1), .b(rdata2), .imm(imm), .pc(pc), .csrData(csrData),
    .aSel(aSel), .bSel(bSel), .aluOp(aluOp), .brUn(brUn),
    .aluOut(aluOut), .brEq(brEq), .brLt(brLt)
  );

  csrFile csrFile_inst (
    .clk(clk), .arstN(arstN), .csrEn(csrEn), .ecall(ecall),
    .csrId(inst.i.imm11_0), .wdata(aluOut), .pc(pc),
    .rdata(csrData), .mtvec(mtvec), .mepc(mepc)
  );

  loadStoreUnit loadStoreUnit_inst (
    .addr(aluOut), .storeData(rdata2), .memSize(memSize),
    .memUnsigned(memUnsigned), .memRdata(memRdata),
    .memWdata(memWdata), .memWmask(memWmask), .loadData(loadData)
  );

endmodule

/* testbench/rvCoreTb.sv */
`timescale 1ns/100ps

module rvCoreTb;
  import rvCorePkg::*;

  localparam logic [31:0] resetVector = 32'h80000000;
  localparam logic [31:0] nopWord     = 32'h00000013;
  localparam logic [31:0] ebreakWord  = 32'h00100073;
  localparam int maxCycles = 400;
  localparam int maxRun    = 100;

  logic        clk;
  logic        arstN;
  logic [31:0] inst;
  logic [31:0] pc;
  logic [31:0] nextPc;
  logic [31:0] memAddr;
  logic [31:0] memWdata;
  logic [3:0]  memWmask;
  logic        memRead;
  logic        memWrite;
  logic [31:0] memRdata;
  logic        halt;

  logic [31:0] imem [64];
  logic [31:0] dmem [64];
  int          progLen;
  int          errorCount = 0;
  int          checkCount = 0;
  int          cycleCount = 0;
  logic [31:0] rngState = 32'h608ec24c;

  // Per-cycle observations of one program run
  logic [31:0] pcQ[$];
  logic [31:0] nextQ[$];
  logic [31:0] wAddrQ[$];
  logic [31:0] wDataQ[$];
  logic [3:0]  wMaskQ[$];
  logic [31:0] expQ[$];

  rvCore #(.resetVector(resetVector)) rvCore_inst (
    .clk(clk), .arstN(arstN), .inst(inst), .pc(pc), .nextPc(nextPc),
    .memAddr(memAddr), .memWdata(memWdata), .memWmask(memWmask),
    .memRead(memRead), .memWrite(memWrite), .memRdata(memRdata), .halt(halt)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Data memory of 64 words mirrored on address bits 7 to 2
  always_comb memRdata = memRead ? dmem[memAddr[7:2]] : 32'd0;

  always @(posedge clk) begin
    if (memWrite) begin
      for (int b = 0; b < 4; b++) begin
        if (memWmask[b]) dmem[memAddr[7:2]][8*b +: 8] <= memWdata[8*b +: 8];
      end
    end
  end

  initial begin
    while (cycleCount < maxCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("ERROR: simulation timed out after %0d cycles", maxCycles);
    $display("Test FAILED");
    $finish;
  end

  function automatic logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  // Instruction encoders for each format
  function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opOp};
  endfunction

  function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
  endfunction

  function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
  endfunction

  function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
      input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
  endfunction

  function automatic logic [31:0] pcOf(input int idx);
    return resetVector + 32'(4 * idx);
  endfunction

  function automatic logic [31:0] fetch(input logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - resetVector) >> 2;
    if (idx < 64) return imem[idx[5:0]];
    return nopWord;
  endfunction

  // RV32I reference results for the ten register-register operations
  function automatic logic [31:0] aluRef(input int k, input logic [31:0] a,
      input logic [31:0] b);
    case (k)
      0: return a + b;
      1: return a - b;
      2: return a & b;
      3: return a | b;
      4: return a ^ b;
      5: return a << b[4:0];
      6: return a >> b[4:0];
      7: return $signed(a) >>> b[4:0];
      8: return {31'd0, $signed(a) < $signed(b)};
      default: return {31'd0, a < b};
    endcase
  endfunction

  // funct7 bit 5 and funct3 for the same ten operations
  function automatic logic [3:0] opFields(input int k);
    case (k)
      0: return 4'b0000;
      1: return 4'b1000;
      2: return 4'b0111;
      3: return 4'b0110;
      4: return 4'b0100;
      5: return 4'b0001;
      6: return 4'b0101;
      7: return 4'b1101;
      8: return 4'b0010;
      default: return 4'b0011;
    endcase
  endfunction

  function automatic logic [31:0] laneBits(input logic [3:0] mask);
    return {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
  endfunction

  function automatic logic [31:0] loadRef(input logic [31:0] word, input int off,
      input logic [2:0] f3);
    logic [31:0] s;
    s = word >> (8 * off);
    case (f3)
      3'b000: return {{24{s[7]}}, s[7:0]};
      3'b001: return {{16{s[15]}}, s[15:0]};
      3'b100: return {24'd0, s[7:0]};
      default: return {16'd0, s[15:0]};
    endcase
  endfunction

  function automatic logic branchRef(input logic [2:0] f3, input logic [31:0] a,
      input logic [31:0] b);
    case (f3)
      f3Beq: return a == b;
      f3Bne: return a != b;
      f3Blt: return $signed(a) < $signed(b);
      default: return a >= b;
    endcase
  endfunction

  task automatic checkEq(input string name, input logic [31:0] actual,
      input logic [31:0] expected);
    checkCount++;
    assert (actual === expected) else begin
      errorCount++;
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic clearProgram();
    for (int i = 0; i < 64; i++) imem[i] = nopWord;
    progLen = 0;
  endtask

  task automatic emit(input logic [31:0] word);
    imem[progLen] = word;
    progLen++;
  endtask

  // lui plus addi with the carry from a negative low part folded into the upper part
  task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = (value + 32'h800) >> 12;
    emit(encU(upper[19:0], rd, opLui));
    emit(encI(value[11:0], rd, 3'b000, rd, opOpImm));
  endtask

  task automatic applyReset();
    @(posedge clk);
    #1;
    arstN = 1'b0;
    inst  = 32'd0;
    repeat (4) begin
      @(negedge clk);
      checkEq("pc in reset", pc, resetVector);
      checkEq("memRead in reset", memRead, 1'b0);
      checkEq("memWrite in reset", memWrite, 1'b0);
      checkEq("halt in reset", halt, 1'b0);
      @(posedge clk);
    end
    #1;
    arstN = 1'b1;
    inst  = fetch(pc);
  endtask

  // Runs the loaded program from reset until ebreak
  task automatic runProgram();
    int  n;
    logic done;
    pcQ.delete();
    nextQ.delete();
    wAddrQ.delete();
    wDataQ.delete();
    wMaskQ.delete();
    applyReset();
    done = 1'b0;
    n = 0;
    while (!done && n < maxRun) begin
      @(negedge clk);
      pcQ.push_back(pc);
      nextQ.push_back(nextPc);
      checkEq("halt", halt, inst == ebreakWord);
      if (memWrite) begin
        wAddrQ.push_back(memAddr);
        wDataQ.push_back(memWdata);
        wMaskQ.push_back(memWmask);
      end
      if (halt) begin
        done = 1'b1;
      end else begin
        @(posedge clk);
        #1;
        inst = fetch(pc);
      end
      n++;
    end
    assert (done) else begin
      errorCount++;
      $display("ERROR: program did not reach ebreak within %0d cycles", maxRun);
    end
  endtask

  task automatic checkStore(input int n, input logic [31:0] addr, input logic [31:0] data);
    if (n < wAddrQ.size()) begin
      checkEq("memAddr", wAddrQ[n], addr);
      checkEq("memWdata", wDataQ[n], data);
      checkEq("memWmask", wMaskQ[n], 4'hf);
    end
  endtask

  task automatic checkTrace();
    checkEq("pc trace length", pcQ.size(), expQ.size());
    for (int i = 0; i < expQ.size() && i < pcQ.size(); i++) begin
      checkEq("pc", pcQ[i], expQ[i]);
    end
  endtask

  task automatic testReset();
    clearProgram();
    applyReset();
    @(negedge clk);
    checkEq("pc first cycle", pc, resetVector);
    checkEq("memRead first cycle", memRead, 1'b0);
    checkEq("memWrite first cycle", memWrite, 1'b0);
    checkEq("halt first cycle", halt, 1'b0);
  endtask

  task automatic testArith();
    logic [31:0] a;
    logic [31:0] b;
    logic [3:0]  f;
    a = nextRandom();
    b = nextRandom();
    clearProgram();
    loadConst(5'd1, a);
    loadConst(5'd2, b);
    for (int k = 0; k < 10; k++) begin
      f = opFields(k);
      emit(encR({1'b0, f[3], 5'd0}, 5'd2, 5'd1, f[2:0], 5'd3));
      emit(encS(12'(12'h100 + 4 * k), 5'd3, 5'd0, 3'b010));
    end
    emit(ebreakWord);
    runProgram();
    checkEq("arith store count", wAddrQ.size(), 10);
    for (int k = 0; k < 10; k++) checkStore(k, 32'h100 + 32'(4 * k), aluRef(k, a, b));
  endtask

  task automatic testLoadStore();
    logic [31:0] v;
    logic [31:0] word;
    logic [3:0]  mask;
    logic [2:0]  f3;
    int          off;
    v    = nextRandom();
    word = 32'h80F17F85;
    clearProgram();
    dmem[16] = word;
    loadConst(5'd1, v);
    for (int i = 0; i < 4; i++) emit(encS(12'(12'h180 + i), 5'd1, 5'd0, 3'b000));
    for (int h = 0; h < 2; h++) emit(encS(12'(12'h190 + 2 * h), 5'd1, 5'd0, 3'b001));
    // lb, lbu, lb, lbu, lb, lh, lh, lhu
    for (int j = 0; j < 8; j++) begin
      f3  = (j == 1 || j == 3) ? 3'b100 : (j == 7) ? 3'b101 : (j >= 5) ? 3'b001 : 3'b000;
      off = (j == 2) ? 1 : (j == 3 || j == 4) ? 3 : (j >= 6) ? 2 : 0;
      emit(encI(12'(12'h140 + off), 5'd0, f3, 5'd2, opLoad));
      emit(encS(12'(12'h1A0 + 4 * j), 5'd2, 5'd0, 3'b010));
    end
    emit(ebreakWord);
    runProgram();
    checkEq("load/store count", wAddrQ.size(), 14);
    if (wAddrQ.size() == 14) begin
      for (int i = 0; i < 6; i++) begin
        mask = (i < 4) ? 4'b0001 << i : 4'b0011 << (2 * (i - 4));
        checkEq("memAddr", wAddrQ[i], (i < 4) ? 32'h180 + i : 32'h190 + 2 * (i - 4));
        checkEq("memWmask", wMaskQ[i], mask);
        checkEq("memWdata lanes", wDataQ[i] & laneBits(mask),
                (i < 4) ? {24'd0, v[7:0]} << (8 * i) : {16'd0, v[15:0]} << (16 * (i - 4)));
      end
      for (int j = 0; j < 8; j++) begin
        f3  = (j == 1 || j == 3) ? 3'b100 : (j == 7) ? 3'b101 : (j >= 5) ? 3'b001 : 3'b000;
        off = (j == 2) ? 1 : (j == 3 || j == 4) ? 3 : (j >= 6) ? 2 : 0;
        checkStore(6 + j, 32'h1A0 + 32'(4 * j), loadRef(word, off, f3));
      end
    end
  endtask

  task automatic testControl();
    logic [2:0]  f3;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [31:0] va;
    logic [31:0] vb;
    int          idx;
    clearProgram();
    expQ.delete();
    emit(encI(12'd5, 5'd0, 3'b000, 5'd1, opOpImm));
    emit(encI(12'hFFD, 5'd0, 3'b000, 5'd2, opOpImm));
    expQ.push_back(pcOf(0));
    expQ.push_back(pcOf(1));
    // beq, bne, blt and bgeu each taken once and not taken once
    for (int c = 0; c < 8; c++) begin
      f3 = (c < 2) ? f3Beq : (c < 4) ? f3Bne : (c < 6) ? f3Blt : f3Bgeu;
      ra = (c == 4 || c == 6) ? 5'd2 : 5'd1;
      rb = (c == 0 || c == 3 || c == 4 || c == 6) ? 5'd1 : 5'd2;
      va = (ra == 5'd1) ? 32'd5 : 32'hFFFFFFFD;
      vb = (rb == 5'd1) ? 32'd5 : 32'hFFFFFFFD;
      idx = progLen;
      emit(encB(13'd8, rb, ra, f3));
      emit(nopWord);
      expQ.push_back(pcOf(idx));
      if (!branchRef(f3, va, vb)) expQ.push_back(pcOf(idx + 1));
    end
    idx = progLen;
    emit(encJ(21'd12, 5'd3));
    emit(nopWord);
    emit(nopWord);
    emit(encU(20'd0, 5'd5, opAuipc));
    emit(encI(12'd12, 5'd5, 3'b000, 5'd4, opJalr));
    emit(nopWord);
    emit(encS(12'h1C0, 5'd3, 5'd0, 3'b010));
    emit(encS(12'h1C4, 5'd4, 5'd0, 3'b010));
    emit(ebreakWord);
    expQ.push_back(pcOf(idx));
    for (int k = 3; k <= 8; k++) if (k != 5) expQ.push_back(pcOf(idx + k));
    runProgram();
    checkTrace();
    checkEq("control store count", wAddrQ.size(), 2);
    checkStore(0, 32'h1C0, pcOf(idx) + 4);
    checkStore(1, 32'h1C4, pcOf(idx + 4) + 4);
  endtask

  task automatic testTrap();
    clearProgram();
    expQ.delete();
    loadConst(5'd1, pcOf(16));
    emit(encI(csrMtvec, 5'd1, f3Csrrw, 5'd0, opSystem));
    emit(encI(12'h000, 5'd0, 3'b000, 5'd0, opSystem));
    emit(encU(20'd1, 5'd8, opLui));
    emit(encI(csrMstatus, 5'd8, f3Csrrc, 5'd9, opSystem));
    emit(encI(csrMstatus, 5'd0, f3Csrrs, 5'd10, opSystem));
    emit(encS(12'h1E8, 5'd9, 5'd0, 3'b010));
    emit(encS(12'h1EC, 5'd10, 5'd0, 3'b010));
    emit(ebreakWord);
    // Handler returns past the ecall
    progLen = 16;
    emit(encI(csrMepc, 5'd0, f3Csrrs, 5'd6, opSystem));
    emit(encS(12'h1E0, 5'd6, 5'd0, 3'b010));
    emit(encI(csrMcause, 5'd0, f3Csrrs, 5'd7, opSystem));
    emit(encS(12'h1E4, 5'd7, 5'd0, 3'b010));
    emit(encI(12'd4, 5'd6, 3'b000, 5'd6, opOpImm));
    emit(encI(csrMepc, 5'd6, f3Csrrw, 5'd0, opSystem));
    emit(encI(12'h302, 5'd0, 3'b000, 5'd0, opSystem));
    for (int i = 0; i < 4; i++) expQ.push_back(pcOf(i));
    for (int i = 16; i < 23; i++) expQ.push_back(pcOf(i));
    for (int i = 4; i < 10; i++) expQ.push_back(pcOf(i));
    runProgram();
    checkTrace();
    if (nextQ.size() > 10) begin
      checkEq("nextPc at ecall", nextQ[3], pcOf(16));
      checkEq("nextPc at mret", nextQ[10], pcOf(4));
    end
    checkEq("trap store count", wAddrQ.size(), 4);
    checkStore(0, 32'h1E0, pcOf(3));
    checkStore(1, 32'h1E4, 32'd11);
    checkStore(2, 32'h1E8, 32'h1800);
    checkStore(3, 32'h1EC, 32'h1800 & ~32'h1000);
  endtask

  task automatic testHalt();
    clearProgram();
    emit(encI(12'd1, 5'd0, 3'b000, 5'd1, opOpImm));
    emit(encI(12'd1, 5'd1, 3'b000, 5'd1, opOpImm));
    emit(ebreakWord);
    runProgram();
    checkEq("halt run length", pcQ.size(), 3);
    if (pcQ.size() == 3) begin
      checkEq("pc at halt", pcQ[2], pcOf(2));
    end
  endtask

  initial begin
    arstN = 1'b0;
    inst  = 32'd0;
    for (int i = 0; i < 64; i++) dmem[i] = 32'hC0DE0000 ^ (32'(i) * 32'h00010101);
    testReset();
    testArith();
    testArith();
    testLoadStore();
    testControl();
    testTrap();
    testHalt();
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* rvCore.f */
hw/rvCorePkg.sv
hw/pcUnit.sv
hw/decoder.sv
hw/regFile.sv
hw/alu.sv
hw/csrFile.sv
hw/loadStoreUnit.sv
hw/rvCore.sv
testbench/rvCoreTb.sv

/* Bender.yml */
package:
  name: rvCore

sources:
  - hw/rvCorePkg.sv
  - hw/pcUnit.sv
  - hw/decoder.sv
  - hw/regFile.sv
  - hw/alu.sv
  - hw/csrFile.sv
  - hw/loadStoreUnit.sv
  - hw/rvCore.sv
  - target: test
    files:
      - testbench/rvCoreTb.sv
